// ==== Bender.yml ====
package:
  name: fp_alu

sources:
  - include_dirs:
      - .
    files:
      - fp_alu_pkg.sv
      - fp_issue_if.sv
      - fp_compare_unit.sv
      - fp_bitwise_unit.sv
      - fp_delay_line.sv
      - fp_result_merge.sv
      - fp_alu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fp_alu_properties.sv
      - fp_alu_tb.sv

// ==== fp_alu_consts.svh ====
// Shared constants of the floating-point execution unit
// Word width, register address width and issue-to-result latency

`ifndef FP_ALU_CONSTS_SVH
`define FP_ALU_CONSTS_SVH

// Operand and result word
`define FP_DATA_WIDTH 32

// Destination register address
`define FP_REG_ADDR_WIDTH 8

// Cycles from issue to result, 3 or more
`define FP_ALU_LATENCY 3

`endif

// ==== fp_alu_pkg.sv ====
// Types of the floating-point execution unit
// Opcode enumeration, single-precision field layout and word union

`default_nettype none

`include "fp_alu_consts.svh"

package fp_alu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    // Codes 4'hC to 4'hF are undefined and produce no result
    typedef enum logic [3:0] {
        LDR  = 4'h0,
        ABS  = 4'h1,
        LAND = 4'h2,
        LOR  = 4'h3,
        LXOR = 4'h4,
        LNOT = 4'h5,
        BGT  = 4'h6,
        BLE  = 4'h7,
        BEQ  = 4'h8,
        BNE  = 4'h9,
        SATP = 4'hA,
        SATN = 4'hB
    } opcode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Data words
    ////////////////////////////////////////////////////////////////////////////

    // IEEE 754 single precision layout
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp_fields_t;

    // Logic units see raw bits, ordering logic sees the fields
    typedef union packed {
        fp_fields_t                 fields;
        logic [`FP_DATA_WIDTH-1:0] bits;
    } fp_word_t;

endpackage

`default_nettype wire

// ==== fp_alu_properties.sv ====
// Concurrent assertions for the floating-point execution unit
// Reset quiet output, fixed issue-to-result latency, idle bus zero

`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_alu_properties (
    input logic                          clock,
    input logic                          arst_n,
    input logic                          issue_valid,
    input fp_alu_pkg::opcode_t           issue_opcode,
    input logic                          result_valid,
    input logic [`FP_DATA_WIDTH-1:0]     result_data,
    input logic [`FP_REG_ADDR_WIDTH-1:0] result_dest
);

    logic defined_issue;

    // Number of failed assertions
    int   failure_count = 0;

    // Codes above SATN claim no unit
    assign defined_issue = issue_valid && (issue_opcode <= fp_alu_pkg::SATN);

    quiet_in_reset: assert property (@(posedge clock) !arst_n |-> !result_valid)
        else begin
            $error("result_valid high while arst_n is asserted");
            failure_count++;
        end

    issue_gives_result: assert property (@(posedge clock) disable iff (!arst_n)
        defined_issue |-> ##`FP_ALU_LATENCY result_valid)
        else begin
            $error("defined issue without a result after the fixed latency");
            failure_count++;
        end

    result_has_issue: assert property (@(posedge clock) disable iff (!arst_n)
        result_valid |-> $past(defined_issue, `FP_ALU_LATENCY))
        else begin
            $error("result without a defined issue at the fixed latency");
            failure_count++;
        end

    idle_bus_zero: assert property (@(posedge clock)
        !result_valid |-> (result_data == '0) && (result_dest == '0))
        else begin
            $error("result bus not zero while result_valid is low");
            failure_count++;
        end

endmodule

`default_nettype wire

// ==== fp_alu_tb.sv ====
// Testbench of the floating-point execution unit
// Clock, reset, watchdog, directed tests, result monitor and report

`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_alu_tb;

    localparam int PERIOD_NS    = 100;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 10;
    // 12 bitwise, 40 compare, 12 saturation, 16 mixed
    localparam int NUM_ISSUES   = 80;
    localparam int WATCHDOG_NS  =
        (NUM_ISSUES + RESET_CYCLES + IDLE_CYCLES + `FP_ALU_LATENCY + 20) * PERIOD_NS;

    logic                          clock;
    logic                          arst_n;
    logic                          issue_valid;
    fp_alu_pkg::opcode_t           issue_opcode;
    logic [`FP_DATA_WIDTH-1:0]     issue_a;
    logic [`FP_DATA_WIDTH-1:0]     issue_b;
    logic [`FP_REG_ADDR_WIDTH-1:0] issue_dest;
    logic                          result_valid;
    logic [`FP_DATA_WIDTH-1:0]     result_data;
    logic [`FP_REG_ADDR_WIDTH-1:0] result_dest;

    // Expected results in issue order
    fp_alu_pkg::fp_word_t          exp_data_q [$];
    logic [`FP_REG_ADDR_WIDTH-1:0] exp_dest_q [$];
    int                            exp_cycle_q [$];

    int                            cycle;
    integer                        seed;
    logic [`FP_REG_ADDR_WIDTH-1:0] next_dest;
    int                            data_errors;
    int                            dest_errors;
    int                            cycle_errors;
    int                            other_errors;
    int                            assertion_errors;

    fp_alu_top u_fp_alu_top (
        .clock        (clock),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_opcode (issue_opcode),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_dest   (issue_dest),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest)
    );

    bind fp_alu_top fp_alu_properties u_properties (
        .clock        (clock),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_opcode (issue_opcode),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest)
    );

    always #(PERIOD_NS / 2) clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Signed key from sign and magnitude, so +0 and -0 both map to 0
    function automatic int order_key(input fp_alu_pkg::fp_word_t w);
        int key;
        key = int'(w.bits[30:0]);
        return w.fields.sign ? -key : key;
    endfunction

    function automatic fp_alu_pkg::fp_word_t model_result(input fp_alu_pkg::opcode_t op,
                                                          input fp_alu_pkg::fp_word_t a,
                                                          input fp_alu_pkg::fp_word_t b);
        fp_alu_pkg::fp_word_t r;
        int ka;
        int kb;
        ka = order_key(a);
        kb = order_key(b);
        case (op)
            fp_alu_pkg::LDR:  r = a;
            fp_alu_pkg::ABS:  r.bits = a.bits & 32'h7fff_ffff;
            fp_alu_pkg::LAND: r.bits = a.bits & b.bits;
            fp_alu_pkg::LOR:  r.bits = a.bits | b.bits;
            fp_alu_pkg::LXOR: r.bits = a.bits ^ b.bits;
            fp_alu_pkg::LNOT: r.bits = a.bits ^ 32'hffff_ffff;
            fp_alu_pkg::BGT:  r.bits = (ka > kb) ? 32'hffff_ffff : 32'h0;
            fp_alu_pkg::BLE:  r.bits = (ka <= kb) ? 32'hffff_ffff : 32'h0;
            fp_alu_pkg::BEQ:  r.bits = (ka == kb) ? 32'hffff_ffff : 32'h0;
            fp_alu_pkg::BNE:  r.bits = (ka != kb) ? 32'hffff_ffff : 32'h0;
            fp_alu_pkg::SATP: r = (ka < kb) ? a : b;
            fp_alu_pkg::SATN: r = (ka < kb) ? b : a;
            default:          r.bits = 32'h0;
        endcase
        return r;
    endfunction

    // Ordinary number, exponent kept below the NaN and infinity code
    function automatic fp_alu_pkg::fp_word_t random_number();
        fp_alu_pkg::fp_word_t w;
        w.bits = $random(seed);
        if (w.fields.exponent == 8'hff) begin
            w.fields.exponent = 8'hfe;
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_word(input string name, input fp_alu_pkg::fp_word_t got,
                                input fp_alu_pkg::fp_word_t exp);
        if (got.bits !== exp.bits) begin
            data_errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got.bits, exp.bits);
        end
    endtask

    task automatic compare_dest(input string name,
                                input logic [`FP_REG_ADDR_WIDTH-1:0] got,
                                input logic [`FP_REG_ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            dest_errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_cycle(input string name, input int got, input int exp);
        if (got != exp) begin
            cycle_errors++;
            $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Results are stable between rising edges
    always @(negedge clock) begin
        if (arst_n && result_valid) begin
            if (exp_data_q.size() == 0) begin
                other_errors++;
                $display("error at %0t ns: result arrived with no operation in flight", $time);
            end else begin
                compare_word("result_data", result_data, exp_data_q.pop_front());
                compare_dest("result_dest", result_dest, exp_dest_q.pop_front());
                compare_cycle("result cycle", cycle, exp_cycle_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue_op(input fp_alu_pkg::opcode_t op, input fp_alu_pkg::fp_word_t a,
                            input fp_alu_pkg::fp_word_t b);
        @(negedge clock);
        issue_valid  = 1'b1;
        issue_opcode = op;
        issue_a      = a.bits;
        issue_b      = b.bits;
        issue_dest   = next_dest;
        if (op <= fp_alu_pkg::SATN) begin
            exp_data_q.push_back(model_result(op, a, b));
            exp_dest_q.push_back(next_dest);
            exp_cycle_q.push_back(cycle + `FP_ALU_LATENCY);
        end
        next_dest = next_dest + 1;
    endtask

    task automatic check_idle();
        @(negedge clock);
        issue_valid = 1'b0;
        repeat (IDLE_CYCLES) begin
            @(negedge clock);
            if (result_valid) begin
                other_errors++;
                $display("error at %0t ns: result_valid high with nothing issued", $time);
            end
        end
    endtask

    task automatic test_bitwise();
        for (int i = 0; i < 12; i++) begin
            issue_op(fp_alu_pkg::opcode_t'(i % 6), $random(seed), $random(seed));
        end
    endtask

    task automatic compare_pair(input logic [31:0] a, input logic [31:0] b);
        issue_op(fp_alu_pkg::BGT, a, b);
        issue_op(fp_alu_pkg::BLE, a, b);
        issue_op(fp_alu_pkg::BEQ, a, b);
        issue_op(fp_alu_pkg::BNE, a, b);
    endtask

    task automatic test_compare();
        compare_pair(32'h3f80_0000, 32'h4000_0000);
        compare_pair(32'h4000_0000, 32'h3f80_0000);
        compare_pair(32'hbf80_0000, 32'h3f80_0000);
        compare_pair(32'h3f80_0000, 32'hbf80_0000);
        compare_pair(32'hc000_0000, 32'hbf80_0000);
        compare_pair(32'hbf80_0000, 32'hc000_0000);
        compare_pair(32'h3fc0_0000, 32'h3fc0_0000);
        compare_pair(32'h0000_0000, 32'h8000_0000);
        compare_pair(32'h8000_0000, 32'h0000_0000);
        compare_pair(32'hc040_0000, 32'h4040_0000);
    endtask

    task automatic saturate_pair(input logic [31:0] a, input logic [31:0] b);
        issue_op(fp_alu_pkg::SATP, a, b);
        issue_op(fp_alu_pkg::SATN, a, b);
    endtask

    task automatic test_saturate();
        // Bounds of +2.0 and -2.0 with values inside and outside them
        saturate_pair(32'h3f80_0000, 32'h4000_0000);
        saturate_pair(32'h4040_0000, 32'h4000_0000);
        saturate_pair(32'hc040_0000, 32'h4000_0000);
        saturate_pair(32'hbf80_0000, 32'hc000_0000);
        saturate_pair(32'hc040_0000, 32'hc000_0000);
        saturate_pair(32'h4040_0000, 32'hc000_0000);
    endtask

    task automatic test_mixed();
        for (int i = 0; i < 16; i++) begin
            if (i == 7) begin
                issue_op(fp_alu_pkg::opcode_t'(4'hD), random_number(), random_number());
            end else if (i % 2 == 0) begin
                issue_op(fp_alu_pkg::opcode_t'((i / 2) % 6), random_number(), random_number());
            end else begin
                issue_op(fp_alu_pkg::opcode_t'(6 + (i / 2) % 6), random_number(),
                         random_number());
            end
        end
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    task automatic drain_results();
        while (exp_data_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (`FP_ALU_LATENCY + 2) @(negedge clock);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clock            = 1'b0;
        arst_n           = 1'b0;
        issue_valid      = 1'b0;
        issue_opcode     = fp_alu_pkg::LDR;
        issue_a          = '0;
        issue_b          = '0;
        issue_dest       = '0;
        cycle            = 0;
        seed             = 32'ha99d_312d;
        next_dest        = '0;
        data_errors      = 0;
        dest_errors      = 0;
        cycle_errors     = 0;
        other_errors     = 0;
        assertion_errors = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        check_idle();
        test_bitwise();
        test_compare();
        test_saturate();
        test_mixed();
        drain_results();

        assertion_errors = u_fp_alu_top.u_properties.failure_count;
        $display("Error counts: data %0d, dest %0d, cycle %0d, other %0d, assertion %0d",
                 data_errors, dest_errors, cycle_errors, other_errors, assertion_errors);
        if (data_errors + dest_errors + cycle_errors + other_errors
            + assertion_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fp_alu_top.f ====
+incdir+.
fp_alu_pkg.sv
fp_issue_if.sv
fp_compare_unit.sv
fp_bitwise_unit.sv
fp_delay_line.sv
fp_result_merge.sv
fp_alu_top.sv
fp_alu_properties.sv
fp_alu_tb.sv

// ==== fp_alu_top.sv ====
// Top level of the floating-point execution unit
// Issue bundle, bitwise and compare units, delay lines and merge

`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_alu_top (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          issue_valid,
    input  fp_alu_pkg::opcode_t           issue_opcode,
    input  logic [`FP_DATA_WIDTH-1:0]     issue_a,
    input  logic [`FP_DATA_WIDTH-1:0]     issue_b,
    input  logic [`FP_REG_ADDR_WIDTH-1:0] issue_dest,
    output logic                          result_valid,
    output logic [`FP_DATA_WIDTH-1:0]     result_data,
    output logic [`FP_REG_ADDR_WIDTH-1:0] result_dest
);

    fp_issue_if issue_bus ();

    logic                          bit_valid;
    fp_alu_pkg::fp_word_t          bit_data;
    logic [`FP_REG_ADDR_WIDTH-1:0] bit_dest;
    logic                          cmp_valid;
    fp_alu_pkg::fp_word_t          cmp_data;
    logic [`FP_REG_ADDR_WIDTH-1:0] cmp_dest;

    logic                          bit_pad_valid;
    fp_alu_pkg::fp_word_t          bit_pad_data;
    logic [`FP_REG_ADDR_WIDTH-1:0] bit_pad_dest;
    logic                          cmp_pad_valid;
    fp_alu_pkg::fp_word_t          cmp_pad_data;
    logic [`FP_REG_ADDR_WIDTH-1:0] cmp_pad_dest;
    fp_alu_pkg::fp_word_t          merged_data;

    // Issue side of the bundle
    assign issue_bus.valid  = issue_valid;
    assign issue_bus.opcode = issue_opcode;
    assign issue_bus.a      = issue_a;
    assign issue_bus.b      = issue_b;
    assign issue_bus.dest   = issue_dest;

    fp_bitwise_unit u_bitwise (
        .clock     (clock),
        .arst_n    (arst_n),
        .issue     (issue_bus),
        .out_valid (bit_valid),
        .out_data  (bit_data),
        .out_dest  (bit_dest)
    );

    fp_compare_unit u_compare (
        .clock     (clock),
        .arst_n    (arst_n),
        .issue     (issue_bus),
        .out_valid (cmp_valid),
        .out_data  (cmp_data),
        .out_dest  (cmp_dest)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Padding to the common latency
    ////////////////////////////////////////////////////////////////////////////

    fp_delay_line #(
        .STAGES (`FP_ALU_LATENCY - 1)
    ) u_bit_pad (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (bit_valid),
        .in_data   (bit_data),
        .in_dest   (bit_dest),
        .out_valid (bit_pad_valid),
        .out_data  (bit_pad_data),
        .out_dest  (bit_pad_dest)
    );

    fp_delay_line #(
        .STAGES (`FP_ALU_LATENCY - 2)
    ) u_cmp_pad (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (cmp_valid),
        .in_data   (cmp_data),
        .in_dest   (cmp_dest),
        .out_valid (cmp_pad_valid),
        .out_data  (cmp_pad_data),
        .out_dest  (cmp_pad_dest)
    );

    fp_result_merge u_merge (
        .bit_valid    (bit_pad_valid),
        .bit_data     (bit_pad_data),
        .bit_dest     (bit_pad_dest),
        .cmp_valid    (cmp_pad_valid),
        .cmp_data     (cmp_pad_data),
        .cmp_dest     (cmp_pad_dest),
        .result_valid (result_valid),
        .result_data  (merged_data),
        .result_dest  (result_dest)
    );

    assign result_data = merged_data.bits;

endmodule

`default_nettype wire

// ==== fp_bitwise_unit.sv ====
// Single-stage bitwise unit
// Load passthrough, absolute value and logic operations

`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_bitwise_unit (
    input  logic                          clock,
    input  logic                          arst_n,
    fp_issue_if.unit                      issue,
    output logic                          out_valid,
    output fp_alu_pkg::fp_word_t          out_data,
    output logic [`FP_REG_ADDR_WIDTH-1:0] out_dest
);

    logic                 claim;
    fp_alu_pkg::fp_word_t abs_word;
    fp_alu_pkg::fp_word_t result;

    // Only the sign field changes for ABS
    always_comb begin
        abs_word             = issue.a;
        abs_word.fields.sign = 1'b0;
    end

    always_comb begin
        claim       = 1'b1;
        result.bits = '0;
        case (issue.opcode)
            fp_alu_pkg::LDR:  result      = issue.a;
            fp_alu_pkg::ABS:  result      = abs_word;
            fp_alu_pkg::LAND: result.bits = issue.a.bits & issue.b.bits;
            fp_alu_pkg::LOR:  result.bits = issue.a.bits | issue.b.bits;
            fp_alu_pkg::LXOR: result.bits = issue.a.bits ^ issue.b.bits;
            fp_alu_pkg::LNOT: result.bits = ~issue.a.bits;
            default:          claim       = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= issue.valid && claim;
        end
    end

    always_ff @(posedge clock) begin
        if (issue.valid && claim) begin
            out_data <= result;
            out_dest <= issue.dest;
        end
    end

endmodule

`default_nettype wire

// ==== fp_compare_unit.sv ====
// Two-stage float compare unit
// Comparisons BGT, BLE, BEQ, BNE and saturation SATP, SATN

`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_compare_unit (
    input  logic                          clock,
    input  logic                          arst_n,
    fp_issue_if.unit                      issue,
    output logic                          out_valid,
    output fp_alu_pkg::fp_word_t          out_data,
    output logic [`FP_REG_ADDR_WIDTH-1:0] out_dest
);

    logic        claim;
    logic [30:0] mag_a;
    logic [30:0] mag_b;
    logic        both_zero;
    logic        a_lt_b;
    logic        a_eq_b;

    // Stage one registers
    logic                          s1_valid;
    fp_alu_pkg::opcode_t           s1_opcode;
    fp_alu_pkg::fp_word_t          s1_a;
    fp_alu_pkg::fp_word_t          s1_b;
    logic [`FP_REG_ADDR_WIDTH-1:0] s1_dest;
    logic                          s1_lt;
    logic                          s1_eq;

    fp_alu_pkg::fp_word_t          result;

    always_comb begin
        case (issue.opcode)
            fp_alu_pkg::BGT,
            fp_alu_pkg::BLE,
            fp_alu_pkg::BEQ,
            fp_alu_pkg::BNE,
            fp_alu_pkg::SATP,
            fp_alu_pkg::SATN: claim = 1'b1;
            default:          claim = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sign-magnitude ordering
    ////////////////////////////////////////////////////////////////////////////

    assign mag_a     = {issue.a.fields.exponent, issue.a.fields.mantissa};
    assign mag_b     = {issue.b.fields.exponent, issue.b.fields.mantissa};
    // +0 and -0 compare equal
    assign both_zero = (mag_a == '0) && (mag_b == '0);
    assign a_eq_b    = both_zero || (issue.a.bits == issue.b.bits);

    always_comb begin
        if (both_zero) begin
            a_lt_b = 1'b0;
        end else if (issue.a.fields.sign != issue.b.fields.sign) begin
            // Negative side is the smaller one
            a_lt_b = issue.a.fields.sign;
        end else if (issue.a.fields.sign) begin
            a_lt_b = mag_a > mag_b;
        end else begin
            a_lt_b = mag_a < mag_b;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid && claim;
        end
    end

    always_ff @(posedge clock) begin
        s1_opcode <= issue.opcode;
        s1_a      <= issue.a;
        s1_b      <= issue.b;
        s1_dest   <= issue.dest;
        s1_lt     <= a_lt_b;
        s1_eq     <= a_eq_b;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result forming
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (s1_opcode)
            fp_alu_pkg::BGT:  result.bits = {`FP_DATA_WIDTH{!s1_lt && !s1_eq}};
            fp_alu_pkg::BLE:  result.bits = {`FP_DATA_WIDTH{s1_lt || s1_eq}};
            fp_alu_pkg::BEQ:  result.bits = {`FP_DATA_WIDTH{s1_eq}};
            fp_alu_pkg::BNE:  result.bits = {`FP_DATA_WIDTH{!s1_eq}};
            // Clamp a to upper bound b
            fp_alu_pkg::SATP: result = s1_lt ? s1_a : s1_b;
            // Clamp a to lower bound b
            fp_alu_pkg::SATN: result = s1_lt ? s1_b : s1_a;
            default:          result.bits = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (s1_valid) begin
            out_data <= result;
            out_dest <= s1_dest;
        end
    end

endmodule

`default_nettype wire

// ==== fp_delay_line.sv ====
// Result delay line
// Pads a functional unit output to the common latency

`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_delay_line #(
    parameter int STAGES = 1
) (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  fp_alu_pkg::fp_word_t          in_data,
    input  logic [`FP_REG_ADDR_WIDTH-1:0] in_dest,
    output logic                          out_valid,
    output fp_alu_pkg::fp_word_t          out_data,
    output logic [`FP_REG_ADDR_WIDTH-1:0] out_dest
);

    logic [STAGES-1:0]             valid_q;
    fp_alu_pkg::fp_word_t          data_q [STAGES];
    logic [`FP_REG_ADDR_WIDTH-1:0] dest_q [STAGES];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload moves only with a valid entry
    always_ff @(posedge clock) begin
        if (in_valid) begin
            data_q[0] <= in_data;
            dest_q[0] <= in_dest;
        end
        for (int i = 1; i < STAGES; i++) begin
            if (valid_q[i-1]) begin
                data_q[i] <= data_q[i-1];
                dest_q[i] <= dest_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[STAGES-1];
    assign out_data  = data_q[STAGES-1];
    assign out_dest  = dest_q[STAGES-1];

endmodule

`default_nettype wire

// ==== fp_issue_if.sv ====
// Issue bundle of one operation
// Modport for the issuing side and for the functional units

`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

interface fp_issue_if;

    logic                          valid;
    fp_alu_pkg::opcode_t           opcode;
    fp_alu_pkg::fp_word_t          a;
    fp_alu_pkg::fp_word_t          b;
    logic [`FP_REG_ADDR_WIDTH-1:0] dest;

    modport issuer (
        output valid,
        output opcode,
        output a,
        output b,
        output dest
    );

    modport unit (
        input valid,
        input opcode,
        input a,
        input b,
        input dest
    );

endinterface

`default_nettype wire

// ==== fp_result_merge.sv ====
// Result merge stage
// Forwards whichever padded unit result is valid

`timescale 1ns/1ps
`default_nettype none

`include "fp_alu_consts.svh"

module fp_result_merge (
    input  logic                          bit_valid,
    input  fp_alu_pkg::fp_word_t          bit_data,
    input  logic [`FP_REG_ADDR_WIDTH-1:0] bit_dest,
    input  logic                          cmp_valid,
    input  fp_alu_pkg::fp_word_t          cmp_data,
    input  logic [`FP_REG_ADDR_WIDTH-1:0] cmp_dest,
    output logic                          result_valid,
    output fp_alu_pkg::fp_word_t          result_data,
    output logic [`FP_REG_ADDR_WIDTH-1:0] result_dest
);

    // One issue claims one unit, so the valids never overlap
    assign result_valid = bit_valid | cmp_valid;

    always_comb begin
        if (bit_valid) begin
            result_data = bit_data;
            result_dest = bit_dest;
        end else if (cmp_valid) begin
            result_data = cmp_data;
            result_dest = cmp_dest;
        end else begin
            // Idle bus reads as zero
            result_data.bits = '0;
            result_dest      = '0;
        end
    end

endmodule

`default_nettype wire
